//--- compile.f
hw/rx_dsp_pkg.sv
hw/dsp_regs.sv
hw/code_history.sv
hw/comb_ffe.sv
hw/pam4_slicer.sv
hw/symbol_aligner.sv
hw/bits_estimator_datapath.sv
hw/rx_dsp_top.sv
test/rx_dsp_chk.sv
test/rx_dsp_tb.sv

//--- hw/bits_estimator_datapath.sv
`timescale 1ns/1ps

module bits_estimator_datapath import rx_dsp_pkg::*; #(
    parameter int ffe_taps = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  code_frame_t codes_in,
    input  eq_cfg_t     cfg,
    output code_frame_t codes_out,
    output est_frame_t  est_out,
    output sym_frame_t  sym_out
);

    code_frame_t cur;
    code_frame_t prev;
    sym_frame_t  sliced;

    code_history hist_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .codes_in(codes_in),
        .cur     (cur),
        .prev    (prev)
    );

    // Raw codes wait one stage to line up with est_out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            codes_out <= '0;
        end else begin
            codes_out <= cur;
        end
    end

    comb_ffe #(
        .ffe_taps(ffe_taps)
    ) cffe_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cur         (cur),
        .prev        (prev),
        .weights     (cfg.weights),
        .disable_mask(cfg.disable_mask),
        .shift       (cfg.shift),
        .est         (est_out)
    );

    pam4_slicer slicer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .est      (est_out),
        .bit_level(cfg.bit_level),
        .sym      (sliced)
    );

    symbol_aligner algn_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .sym_in   (sliced),
        .align_pos(cfg.align_pos),
        .sym_out  (sym_out)
    );

endmodule

//--- hw/code_history.sv
`timescale 1ns/1ps

module code_history import rx_dsp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  code_frame_t codes_in,
    output code_frame_t cur,
    output code_frame_t prev
);

    // Set once the first valid frame has been captured
    logic seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur  <= '0;
            prev <= '0;
            seen <= 1'b0;
        end else begin
            cur.valid <= codes_in.valid;
            seen      <= seen | codes_in.valid;
            // Codes only advance on valid frames so gaps keep the history
            if (codes_in.valid) begin
                cur.code   <= codes_in.code;
                prev.code  <= cur.code;
                prev.valid <= seen;
            end
        end
    end

endmodule

//--- hw/comb_ffe.sv
`timescale 1ns/1ps

module comb_ffe import rx_dsp_pkg::*; #(
    parameter int ffe_taps = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  code_frame_t               cur,
    input  code_frame_t               prev,
    input  weight_t [max_taps-1:0]    weights,
    input  logic [max_taps*lanes-1:0] disable_mask,
    input  logic [shift_w-1:0]        shift,
    output est_frame_t                est
);

    localparam int prod_w = code_w + weight_w;
    localparam int acc_w  = prod_w + $clog2(max_taps);

    localparam logic signed [acc_w-1:0] est_max = acc_w'(2 ** (est_w - 1) - 1);
    localparam logic signed [acc_w-1:0] est_min = -acc_w'(2 ** (est_w - 1));

    code_t                    hist [2*lanes];
    logic signed [prod_w-1:0] prod [lanes][max_taps];
    logic signed [acc_w-1:0]  acc [lanes];
    logic signed [acc_w-1:0]  shifted [lanes];
    est_frame_t               est_d;

    // Previous frame in 0..3, current frame in 4..7
    always_comb begin
        for (int j = 0; j < lanes; j++) begin
            hist[j]         = prev.valid ? prev.code[j] : '0;
            hist[lanes + j] = cur.code[j];
        end
    end

    always_comb begin
        est_d.valid = cur.valid;
        for (int i = 0; i < lanes; i++) begin
            acc[i] = '0;
            for (int t = 0; t < max_taps; t++) begin
                prod[i][t] = $signed(weights[t]) * $signed(hist[lanes + i - t]);
                if (t < ffe_taps && !disable_mask[t * lanes + i]) begin
                    acc[i] = acc[i] + prod[i][t];
                end
            end
            shifted[i] = acc[i] >>> shift;
            if (shifted[i] > est_max) begin
                est_d.est[i] = est_max[est_w-1:0];
            end else if (shifted[i] < est_min) begin
                est_d.est[i] = est_min[est_w-1:0];
            end else begin
                est_d.est[i] = shifted[i][est_w-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            est <= '0;
        end else begin
            est <= est_d;
        end
    end

endmodule

//--- hw/dsp_regs.sv
`timescale 1ns/1ps

module dsp_regs import rx_dsp_pkg::*; #(
    parameter int ffe_taps = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [wb_adr_w-1:0] adr,
    input  logic [wb_dat_w-1:0] dat_w,
    output logic [wb_dat_w-1:0] dat_r,
    output logic                ack,
    output eq_cfg_t             cfg
);

    localparam logic [wb_adr_w-1:0] tap_lim = wb_adr_w'(ffe_taps);

    logic                access;
    logic                weight_ok;
    wb_addr_e            addr;
    weight_t             weight_rd;
    logic [wb_dat_w-1:0] rd_data;

    // New request while no ack is pending
    assign access    = cyc && stb && !ack;
    assign addr      = wb_addr_e'(adr);
    assign weight_ok = adr < tap_lim;
    assign weight_rd = cfg.weights[adr[1:0]];

    always_comb begin
        rd_data = '0;
        case (addr)
            WEIGHT0, WEIGHT1, WEIGHT2, WEIGHT3: begin
                if (weight_ok) begin
                    rd_data = {{(wb_dat_w - weight_w){weight_rd[weight_w-1]}}, weight_rd};
                end
            end
            SHIFT: begin
                rd_data = {{(wb_dat_w - shift_w){1'b0}}, cfg.shift};
            end
            BIT_LEVEL: begin
                rd_data = {{(wb_dat_w - est_w){cfg.bit_level[est_w-1]}}, cfg.bit_level};
            end
            ALIGN_POS: begin
                rd_data = {{(wb_dat_w - align_w){1'b0}}, cfg.align_pos};
            end
            DISABLE: begin
                rd_data = {{(wb_dat_w - max_taps * lanes){1'b0}}, cfg.disable_mask};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
            cfg <= '0;
        end else begin
            ack <= access;
            if (access && we) begin
                case (addr)
                    WEIGHT0, WEIGHT1, WEIGHT2, WEIGHT3: begin
                        // Slots past the last tap stay zero
                        if (weight_ok) begin
                            cfg.weights[adr[1:0]] <= dat_w[weight_w-1:0];
                        end
                    end
                    SHIFT:     cfg.shift        <= dat_w[shift_w-1:0];
                    BIT_LEVEL: cfg.bit_level    <= dat_w[est_w-1:0];
                    ALIGN_POS: cfg.align_pos    <= dat_w[align_w-1:0];
                    DISABLE:   cfg.disable_mask <= dat_w[max_taps*lanes-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data sampled with the access, valid while ack is high
    always_ff @(posedge clk) begin
        if (access) begin
            dat_r <= rd_data;
        end
    end

endmodule

//--- hw/pam4_slicer.sv
`timescale 1ns/1ps

module pam4_slicer import rx_dsp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  est_frame_t est,
    input  est_t       bit_level,
    output sym_frame_t sym
);

    // One extra bit so the negated level cannot overflow
    logic signed [est_w:0] level;
    logic signed [est_w:0] neg_level;
    logic signed [est_w:0] sample [lanes];
    sym_frame_t            sym_d;

    assign level     = $signed({bit_level[est_w-1], bit_level});
    assign neg_level = -level;

    always_comb begin
        sym_d.valid = est.valid;
        for (int i = 0; i < lanes; i++) begin
            sample[i] = $signed({est.est[i][est_w-1], est.est[i]});
            if (sample[i] >= level) begin
                sym_d.sym[i] = SYM_P3;
            end else if (!sample[i][est_w]) begin
                sym_d.sym[i] = SYM_P1;
            end else if (sample[i] >= neg_level) begin
                sym_d.sym[i] = SYM_N1;
            end else begin
                sym_d.sym[i] = SYM_N3;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym <= '0;
        end else begin
            sym <= sym_d;
        end
    end

endmodule

//--- hw/rx_dsp_pkg.sv
package rx_dsp_pkg;

    localparam int lanes    = 4;
    localparam int code_w   = 8;
    localparam int weight_w = 8;
    localparam int est_w    = 10;
    localparam int shift_w  = 4;
    localparam int max_taps = 4;
    localparam int align_w  = $clog2(lanes);

    // Wishbone port widths
    localparam int wb_adr_w = 3;
    localparam int wb_dat_w = 32;

    typedef logic signed [code_w-1:0]   code_t;
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [est_w-1:0]    est_t;

    typedef enum logic [1:0] {
        SYM_N3 = 2'd0,
        SYM_N1 = 2'd1,
        SYM_P1 = 2'd2,
        SYM_P3 = 2'd3
    } pam4_sym_e;

    // Register word addresses
    typedef enum logic [wb_adr_w-1:0] {
        WEIGHT0   = 3'd0,
        WEIGHT1   = 3'd1,
        WEIGHT2   = 3'd2,
        WEIGHT3   = 3'd3,
        SHIFT     = 3'd4,
        BIT_LEVEL = 3'd5,
        ALIGN_POS = 3'd6,
        DISABLE   = 3'd7
    } wb_addr_e;

    typedef struct packed {
        logic                 valid;
        code_t [lanes-1:0]    code;
    } code_frame_t;

    typedef struct packed {
        logic                 valid;
        est_t [lanes-1:0]     est;
    } est_frame_t;

    typedef struct packed {
        logic                 valid;
        pam4_sym_e [lanes-1:0] sym;
    } sym_frame_t;

    // Disable bit tap*lanes+lane removes one product
    typedef struct packed {
        weight_t [max_taps-1:0]    weights;
        logic [max_taps*lanes-1:0] disable_mask;
        logic [shift_w-1:0]        shift;
        est_t                      bit_level;
        logic [align_w-1:0]        align_pos;
    } eq_cfg_t;

endpackage

//--- hw/rx_dsp_top.sv
`timescale 1ns/1ps

module rx_dsp_top import rx_dsp_pkg::*; #(
    parameter int ffe_taps = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [wb_adr_w-1:0] adr,
    input  logic [wb_dat_w-1:0] dat_w,
    output logic [wb_dat_w-1:0] dat_r,
    output logic                ack,
    input  code_frame_t         codes_in,
    output code_frame_t         codes_out,
    output est_frame_t          est_out,
    output sym_frame_t          sym_out
);

    eq_cfg_t cfg;

    dsp_regs #(
        .ffe_taps(ffe_taps)
    ) regs_i (
        .clk  (clk),
        .rst_n(rst_n),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack  (ack),
        .cfg  (cfg)
    );

    bits_estimator_datapath #(
        .ffe_taps(ffe_taps)
    ) dp_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .codes_in (codes_in),
        .cfg      (cfg),
        .codes_out(codes_out),
        .est_out  (est_out),
        .sym_out  (sym_out)
    );

endmodule

//--- hw/symbol_aligner.sv
`timescale 1ns/1ps

module symbol_aligner import rx_dsp_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  sym_frame_t         sym_in,
    input  logic [align_w-1:0] align_pos,
    output sym_frame_t         sym_out
);

    pam4_sym_e [lanes-1:0] last_sym;
    pam4_sym_e             window [2*lanes];

    // Eight-symbol window, older frame first
    always_comb begin
        for (int j = 0; j < lanes; j++) begin
            window[j]         = last_sym[j];
            window[lanes + j] = sym_in.sym[j];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym_out.valid <= 1'b0;
            for (int i = 0; i < lanes; i++) begin
                last_sym[i]      <= SYM_N3;
                sym_out.sym[i]   <= SYM_N3;
            end
        end else begin
            sym_out.valid <= sym_in.valid;
            for (int i = 0; i < lanes; i++) begin
                sym_out.sym[i] <= window[i + int'(align_pos)];
            end
            // History only follows valid frames
            if (sym_in.valid) begin
                last_sym <= sym_in.sym;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rx_dsp_tb -f compile.f -o rx_dsp_sim

sim_out=$(./obj_dir/rx_dsp_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- test/rx_dsp_chk.sv
`timescale 1ns/1ps

module rx_dsp_chk import rx_dsp_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        cyc,
    input logic        stb,
    input logic        ack,
    input code_frame_t codes_in,
    input est_frame_t  est_out,
    input sym_frame_t  sym_out
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> (cyc && stb))
        else $error("ack high outside an active bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // Estimates two edges behind the input, symbols four
    est_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        est_out.valid == $past(codes_in.valid, 2))
        else $error("est_out.valid out of step with codes_in.valid");

    sym_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        sym_out.valid == $past(codes_in.valid, 4))
        else $error("sym_out.valid out of step with codes_in.valid");

endmodule

//--- test/rx_dsp_tb.sv
`timescale 1ns/1ps

module rx_dsp_tb import rx_dsp_pkg::*; ();

    localparam int ffe_taps     = 3;
    localparam int n_cfg        = 5;
    localparam int rows_per_cfg = 8;
    localparam int n_rows       = n_cfg * rows_per_cfg;
    localparam int bus_ops      = 64;
    localparam int cycle_limit  = n_rows * 4 + bus_ops * 4 + 100;
    localparam int est_hi       = 2 ** (est_w - 1) - 1;
    localparam int est_lo       = -(2 ** (est_w - 1));

    typedef struct packed {
        logic [2:0]            cfg;
        code_t [lanes-1:0]     code;
        est_t [lanes-1:0]      est;
        pam4_sym_e [lanes-1:0] sym;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                cyc;
    logic                stb;
    logic                we;
    logic                ack;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat_w;
    logic [wb_dat_w-1:0] dat_r;
    code_frame_t         codes_in;
    code_frame_t         codes_out;
    est_frame_t          est_out;
    sym_frame_t          sym_out;

    row_t                      rows [n_rows];
    weight_t                   cfg_w [n_cfg][ffe_taps];
    logic [max_taps*lanes-1:0] cfg_mask [n_cfg];
    logic [shift_w-1:0]        cfg_shift [n_cfg];
    est_t                      cfg_level [n_cfg];
    logic [align_w-1:0]        cfg_align [n_cfg];
    // On, just above and just below 0 and +-50
    code_t slicer_codes [12] = '{8'h32, 8'h33, 8'h31, 8'h00, 8'hFF, 8'h01,
                                 8'hCE, 8'hCD, 8'hCF, 8'h7F, 8'h80, 8'h81};
    code_t corner [4] = '{8'h7F, 8'h81, 8'h80, 8'h00};
    integer seed;
    int errors = 0;
    int other_errs = 0;
    int sent_cnt = 0;
    int code_idx = 0;
    int est_idx = 0;
    int sym_idx = 0;
    int cycle_cnt = 0;
    logic [1:0] vld_hist = '0;

    rx_dsp_top #(.ffe_taps(ffe_taps)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got_v);
        if (exp_v !== got_v) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp_v, got_v);
        end
    endtask

    task automatic bus_access(input wb_addr_e a, input logic wr, input logic [31:0] d,
                              output logic [31:0] q);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        @(negedge clk);
        while (!ack) @(negedge clk);
        q = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        if (ack) begin
            other_errs++;
            $display("Bus ack stayed high for a second cycle");
        end
    endtask

    task automatic write_reg(input wb_addr_e a, input logic [31:0] d);
        logic [31:0] unused_q;
        bus_access(a, 1'b1, d, unused_q);
    endtask

    task automatic read_check(input wb_addr_e a, input logic [31:0] exp_v);
        logic [31:0] got;
        bus_access(a, 1'b0, 32'h0, got);
        check_val($sformatf("dat_r[%0d]", a), 64'(exp_v), 64'(got));
    endtask

    task automatic set_cfg(input int c, input weight_t w0, input weight_t w1,
                           input weight_t w2, input logic [15:0] m,
                           input logic [3:0] s, input est_t l, input logic [1:0] a);
        cfg_w[c][0]  = w0;
        cfg_w[c][1]  = w1;
        cfg_w[c][2]  = w2;
        cfg_mask[c]  = m;
        cfg_shift[c] = s;
        cfg_level[c] = l;
        cfg_align[c] = a;
    endtask

    task automatic apply_cfg(input int c);
        for (int t = 0; t < ffe_taps; t++) begin
            write_reg(wb_addr_e'(3'(t)), 32'(cfg_w[c][t]));
        end
        write_reg(SHIFT, 32'(cfg_shift[c]));
        write_reg(BIT_LEVEL, 32'(cfg_level[c]));
        write_reg(ALIGN_POS, 32'(cfg_align[c]));
        write_reg(DISABLE, 32'(cfg_mask[c]));
    endtask

    // Tap t behind lane i, reaching into the previous frame when needed
    function automatic est_t ffe_ref(input int c, input code_t [lanes-1:0] cur,
                                     input code_t [lanes-1:0] prv, input int i);
        int acc;
        int smp;
        acc = 0;
        for (int t = 0; t < ffe_taps; t++) begin
            if (i - t >= 0) begin
                smp = int'(cur[i - t]);
            end else begin
                smp = int'(prv[lanes + i - t]);
            end
            if (!cfg_mask[c][t * lanes + i]) begin
                acc += int'(cfg_w[c][t]) * smp;
            end
        end
        acc = acc >>> cfg_shift[c];
        if (acc > est_hi) begin
            acc = est_hi;
        end else if (acc < est_lo) begin
            acc = est_lo;
        end
        return est_t'(acc);
    endfunction

    function automatic pam4_sym_e slice_ref(input est_t e, input est_t lvl);
        if (int'(e) >= int'(lvl)) begin
            return SYM_P3;
        end else if (int'(e) >= 0) begin
            return SYM_P1;
        end else if (int'(e) >= -int'(lvl)) begin
            return SYM_N1;
        end
        return SYM_N3;
    endfunction

    task automatic build_table();
        code_t [lanes-1:0]     prv;
        pam4_sym_e [lanes-1:0] last;
        pam4_sym_e [lanes-1:0] cur_sym;
        pam4_sym_e             win [2*lanes];
        int                    c;
        prv = '0;
        for (int j = 0; j < lanes; j++) begin
            last[j] = SYM_N3;
        end
        for (int r = 0; r < n_rows; r++) begin
            c = r / rows_per_cfg;
            rows[r].cfg = 3'(c);
            for (int i = 0; i < lanes; i++) begin
                if (c == 4) begin
                    rows[r].code[i] = slicer_codes[(r * lanes + i) % 12];
                end else if (c == 2 || r % 3 == 0) begin
                    rows[r].code[i] = corner[(r + i) % 4];
                end else begin
                    rows[r].code[i] = code_t'($random(seed));
                end
            end
            for (int i = 0; i < lanes; i++) begin
                rows[r].est[i] = ffe_ref(c, rows[r].code, prv, i);
                cur_sym[i] = slice_ref(rows[r].est[i], cfg_level[c]);
            end
            for (int j = 0; j < lanes; j++) begin
                win[j]         = last[j];
                win[lanes + j] = cur_sym[j];
            end
            for (int i = 0; i < lanes; i++) begin
                rows[r].sym[i] = win[i + int'(cfg_align[c])];
            end
            prv  = rows[r].code;
            last = cur_sym;
        end
    endtask

    task automatic check_regs();
        for (int a = 0; a < 8; a++) begin
            read_check(wb_addr_e'(3'(a)), 32'h0);
        end
        write_reg(WEIGHT0, 32'hFFFF_FF85);
        write_reg(WEIGHT1, 32'h0000_017F);
        write_reg(WEIGHT2, 32'h0000_0180);
        write_reg(WEIGHT3, 32'h0000_0012);
        write_reg(SHIFT, 32'hFFFF_FFFF);
        write_reg(BIT_LEVEL, 32'h0000_0300);
        write_reg(ALIGN_POS, 32'h0000_0007);
        write_reg(DISABLE, 32'hFFFF_ABCD);
        read_check(WEIGHT0, 32'hFFFF_FF85);
        read_check(WEIGHT1, 32'h0000_007F);
        read_check(WEIGHT2, 32'hFFFF_FF80);
        read_check(WEIGHT3, 32'h0000_0000);
        read_check(SHIFT, 32'h0000_000F);
        read_check(BIT_LEVEL, 32'hFFFF_FF00);
        read_check(ALIGN_POS, 32'h0000_0003);
        read_check(DISABLE, 32'h0000_ABCD);
    endtask

    // Driven valid bits, newest in bit 0
    always @(posedge clk) begin
        vld_hist <= {vld_hist[0], codes_in.valid};
    end

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rst_n) begin
            check_val("codes_out.valid", 64'(vld_hist[1]), 64'(codes_out.valid));
            if (codes_out.valid) begin
                if (code_idx < sent_cnt) begin
                    check_val("codes_out", 64'(rows[code_idx].code), 64'(codes_out.code));
                end else begin
                    other_errs++;
                    $display("codes_out raised valid with no frame sent");
                end
                code_idx++;
            end
            if (est_out.valid) begin
                if (est_idx < sent_cnt) begin
                    check_val("est_out", 64'(rows[est_idx].est), 64'(est_out.est));
                end else begin
                    other_errs++;
                    $display("est_out raised valid with no frame sent");
                end
                est_idx++;
            end
            if (sym_out.valid) begin
                if (sym_idx < sent_cnt) begin
                    check_val("sym_out", 64'(rows[sym_idx].sym), 64'(sym_out.sym));
                end else begin
                    other_errs++;
                    $display("sym_out raised valid with no frame sent");
                end
                sym_idx++;
            end
        end
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles waiting for the DUT", cycle_limit);
        $display("Errors: %0d value mismatches, %0d other failures", errors, other_errs);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 32'h9103_68b1;
        rst_n    <= 1'b0;
        cyc      <= 1'b0;
        stb      <= 1'b0;
        we       <= 1'b0;
        adr      <= '0;
        dat_w    <= '0;
        codes_in <= '0;
        set_cfg(0, 8'h01, 8'h00, 8'h00, 16'h0000, 4'd0, 10'sd64, 2'd0);
        set_cfg(1, weight_t'($random(seed)), weight_t'($random(seed)),
                weight_t'($random(seed)), 16'h0000, 4'd3, 10'sd100, 2'd1);
        set_cfg(2, 8'h7F, 8'h7F, 8'h80, 16'h0000, 4'd2, 10'sd200, 2'd2);
        set_cfg(3, weight_t'($random(seed)), weight_t'($random(seed)),
                weight_t'($random(seed)), 16'h0A53, 4'd4, 10'sd20, 2'd3);
        set_cfg(4, 8'h01, 8'h00, 8'h00, 16'h0000, 4'd0, 10'sd50, 2'd0);
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_regs();
        for (int c = 0; c < n_cfg; c++) begin
            apply_cfg(c);
            for (int r = 0; r < n_rows; r++) begin
                if (int'(rows[r].cfg) == c) begin
                    @(posedge clk);
                    codes_in <= {1'b1, rows[r].code};
                    sent_cnt++;
                    // Idle cycle inside each group
                    if (r % rows_per_cfg == 5) begin
                        @(posedge clk);
                        codes_in.valid <= 1'b0;
                    end
                end
            end
            @(posedge clk);
            codes_in.valid <= 1'b0;
            while (sym_idx < sent_cnt) @(negedge clk);
        end
        if (code_idx != n_rows || est_idx != n_rows) begin
            other_errs++;
            $display("Frame counts differ from the %0d frames sent", n_rows);
        end
        $display("Errors: %0d value mismatches, %0d other failures", errors, other_errs);
        if (errors == 0 && other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

bind rx_dsp_top rx_dsp_chk chk_i (.*);
